//--- filelist.f
hw/copad_pkg.sv
hw/cluster_if.sv
hw/pad_window.sv
hw/cluster_pair_match.sv
hw/match_collect.sv
hw/copad_finder.sv
verification/copad_finder_props.sv
verification/copad_finder_tb.sv

//--- hw/cluster_if.sv
`timescale 1ns/1ps
`default_nettype none

// one chamber's clusters for one bunch crossing
interface cluster_if #(
    parameter int n_clusters = copad_pkg::default_n_clusters
);

    // valid pattern flag per cluster
    logic [n_clusters-1:0] vpf;

    // cluster fields, index = cluster number
    copad_pkg::roll_t [n_clusters-1:0] roll;
    copad_pkg::pad_t  [n_clusters-1:0] pad;
    copad_pkg::cnt_t  [n_clusters-1:0] cnt;

    // side that fills in the clusters
    modport producer (
        output vpf,
        output roll,
        output pad,
        output cnt
    );

    // matching logic side
    modport consumer (
        input vpf,
        input roll,
        input pad,
        input cnt
    );

endinterface

`default_nettype wire

//--- hw/cluster_pair_match.sv
`timescale 1ns/1ps
`default_nettype none

// every A cluster window against every B cluster
// rows are A clusters, columns B clusters
module cluster_pair_match #(
    parameter int n_clusters = copad_pkg::default_n_clusters
) (
    cluster_if.consumer                            gem_a,
    cluster_if.consumer                            gem_b,
    input  copad_pkg::pad_t [n_clusters-1:0]       win_min,
    input  copad_pkg::pad_t [n_clusters-1:0]       win_max,
    input  logic                                   match_neighbor_roll,
    output logic [n_clusters-1:0][n_clusters-1:0]  same_roll,
    output logic [n_clusters-1:0][n_clusters-1:0]  upper_roll,
    output logic [n_clusters-1:0][n_clusters-1:0]  lower_roll
);

    // B start + count kept one bit wider
    localparam int end_width = copad_pkg::pad_width + 1;

    genvar ia;
    genvar ib;
    generate
        for (ia = 0; ia < n_clusters; ia++) begin : g_a
            for (ib = 0; ib < n_clusters; ib++) begin : g_b
                logic [end_width-1:0] b_end;
                logic [end_width-1:0] lo;
                logic [end_width-1:0] hi;
                logic                 start_in;
                logic                 end_in;
                logic                 pad_overlap;
                logic                 both_valid;
                logic                 roll_same;
                logic                 roll_up;
                logic                 roll_down;

                // --------------------------------------------------
                // pad overlap
                // --------------------------------------------------
                assign lo    = end_width'(win_min[ia]);
                assign hi    = end_width'(win_max[ia]);
                assign b_end = end_width'(gem_b.pad[ib]) + end_width'(gem_b.cnt[ib]);

                // first B pad inside the A window
                assign start_in = (gem_b.pad[ib] >= win_min[ia])
                               && (gem_b.pad[ib] <= win_max[ia]);

                // last B pad inside the A window
                assign end_in = (b_end >= lo) && (b_end <= hi);

                assign pad_overlap = start_in || end_in;

                // --------------------------------------------------
                // roll relation
                // --------------------------------------------------
                assign both_valid = gem_a.vpf[ia] && gem_b.vpf[ib];

                assign roll_same = gem_a.roll[ia] == gem_b.roll[ib];

                // B one roll below A, nothing below roll 0
                assign roll_up = (gem_a.roll[ia] != '0)
                              && (gem_a.roll[ia] == copad_pkg::roll_t'(gem_b.roll[ib] + 1'b1));

                // B one roll above A, nothing above the last roll
                assign roll_down = (gem_a.roll[ia] != copad_pkg::last_roll)
                                && (copad_pkg::roll_t'(gem_a.roll[ia] + 1'b1) == gem_b.roll[ib]);

                assign same_roll[ia][ib] = both_valid && roll_same && pad_overlap;

                // neighbor rolls gated by the config level
                assign upper_roll[ia][ib] = both_valid && roll_up && pad_overlap
                                         && match_neighbor_roll;
                assign lower_roll[ia][ib] = both_valid && roll_down && pad_overlap
                                         && match_neighbor_roll;
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- hw/copad_finder.sv
`timescale 1ns/1ps
`default_nettype none

// co-pad finder for two stacked GEM chambers
// one crossing in per clock, results one clock later
module copad_finder #(
    parameter int n_clusters = copad_pkg::default_n_clusters
) (
    input  logic                                  clock,
    input  logic                                  arst_n,

    // configuration levels
    input  logic                                  match_neighbor_roll,
    input  logic                                  match_neighbor_pad,
    input  copad_pkg::delta_t                     match_delta_pad,

    // chamber A clusters
    input  logic [n_clusters-1:0]                 gem_a_vpf,
    input  copad_pkg::roll_t [n_clusters-1:0]     gem_a_roll,
    input  copad_pkg::pad_t  [n_clusters-1:0]     gem_a_pad,
    input  copad_pkg::cnt_t  [n_clusters-1:0]     gem_a_cnt,

    // chamber B clusters
    input  logic [n_clusters-1:0]                 gem_b_vpf,
    input  copad_pkg::roll_t [n_clusters-1:0]     gem_b_roll,
    input  copad_pkg::pad_t  [n_clusters-1:0]     gem_b_pad,
    input  copad_pkg::cnt_t  [n_clusters-1:0]     gem_b_cnt,

    // per A cluster flags
    output logic [n_clusters-1:0]                 match,
    output logic [n_clusters-1:0]                 match_upper,
    output logic [n_clusters-1:0]                 match_lower,

    // coincidence matrix, A index major
    output logic [n_clusters-1:0][n_clusters-1:0] copad_a_b,
    output logic                                  any_match
);

    // --------------------------------------------------
    // chamber buses
    // --------------------------------------------------
    cluster_if #(.n_clusters(n_clusters)) gem_a ();
    cluster_if #(.n_clusters(n_clusters)) gem_b ();

    assign gem_a.vpf  = gem_a_vpf;
    assign gem_a.roll = gem_a_roll;
    assign gem_a.pad  = gem_a_pad;
    assign gem_a.cnt  = gem_a_cnt;

    assign gem_b.vpf  = gem_b_vpf;
    assign gem_b.roll = gem_b_roll;
    assign gem_b.pad  = gem_b_pad;
    assign gem_b.cnt  = gem_b_cnt;

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------

    // A windows
    copad_pkg::pad_t [n_clusters-1:0] win_min;
    copad_pkg::pad_t [n_clusters-1:0] win_max;

    // pair matrices before the register stage
    logic [n_clusters-1:0][n_clusters-1:0] same_roll;
    logic [n_clusters-1:0][n_clusters-1:0] upper_roll;
    logic [n_clusters-1:0][n_clusters-1:0] lower_roll;

    pad_window #(
        .n_clusters (n_clusters)
    ) u_pad_window (
        .gem_a              (gem_a),
        .match_neighbor_pad (match_neighbor_pad),
        .match_delta_pad    (match_delta_pad),
        .win_min            (win_min),
        .win_max            (win_max)
    );

    cluster_pair_match #(
        .n_clusters (n_clusters)
    ) u_cluster_pair_match (
        .gem_a               (gem_a),
        .gem_b               (gem_b),
        .win_min             (win_min),
        .win_max             (win_max),
        .match_neighbor_roll (match_neighbor_roll),
        .same_roll           (same_roll),
        .upper_roll          (upper_roll),
        .lower_roll          (lower_roll)
    );

    // only clocked stage in the design
    match_collect #(
        .n_clusters (n_clusters)
    ) u_match_collect (
        .clock       (clock),
        .arst_n      (arst_n),
        .same_roll   (same_roll),
        .upper_roll  (upper_roll),
        .lower_roll  (lower_roll),
        .copad_a_b   (copad_a_b),
        .match       (match),
        .match_upper (match_upper),
        .match_lower (match_lower),
        .any_match   (any_match)
    );

endmodule

`default_nettype wire

//--- hw/copad_pkg.sv
`default_nettype none

package copad_pkg;

    // --------------------------------------------------
    // cluster geometry
    // --------------------------------------------------

    // clusters per chamber, per crossing
    localparam int default_n_clusters = 8;

    // field widths
    localparam int pad_width   = 8;
    localparam int roll_width  = 3;
    localparam int cnt_width   = 3;
    localparam int delta_width = 4;

    // --------------------------------------------------
    // field types
    // --------------------------------------------------

    // pad address inside one roll
    typedef logic [pad_width-1:0] pad_t;

    // eta partition index
    typedef logic [roll_width-1:0] roll_t;

    // additional pads after the start pad
    typedef logic [cnt_width-1:0] cnt_t;

    // allowed pad distance, 0 to 15
    typedef logic [delta_width-1:0] delta_t;

    // --------------------------------------------------
    // chamber edges
    // --------------------------------------------------

    // pads 0 to 191 in every roll
    localparam pad_t last_pad = pad_t'(191);

    // rolls 0 to 7, no neighbor past either end
    localparam roll_t last_roll = roll_t'(7);

endpackage

`default_nettype wire

//--- hw/match_collect.sv
`timescale 1ns/1ps
`default_nettype none

// single output register stage for the pair matrices
module match_collect #(
    parameter int n_clusters = copad_pkg::default_n_clusters
) (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  logic [n_clusters-1:0][n_clusters-1:0] same_roll,
    input  logic [n_clusters-1:0][n_clusters-1:0] upper_roll,
    input  logic [n_clusters-1:0][n_clusters-1:0] lower_roll,
    output logic [n_clusters-1:0][n_clusters-1:0] copad_a_b,
    output logic [n_clusters-1:0]                 match,
    output logic [n_clusters-1:0]                 match_upper,
    output logic [n_clusters-1:0]                 match_lower,
    output logic                                  any_match
);

    // any relation per A/B pair
    logic [n_clusters-1:0][n_clusters-1:0] pair_hit;

    // row reductions, one bit per A cluster
    logic [n_clusters-1:0] row_hit;
    logic [n_clusters-1:0] row_upper;
    logic [n_clusters-1:0] row_lower;

    assign pair_hit = same_roll | upper_roll | lower_roll;

    genvar i;
    generate
        for (i = 0; i < n_clusters; i++) begin : g_row
            assign row_hit[i]   = |pair_hit[i];
            assign row_upper[i] = |upper_roll[i];
            assign row_lower[i] = |lower_roll[i];
        end
    endgenerate

    // --------------------------------------------------
    // output registers
    // --------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            copad_a_b   <= '0;
            match       <= '0;
            match_upper <= '0;
            match_lower <= '0;
        end else begin
            copad_a_b   <= pair_hit;
            match       <= row_hit;
            match_upper <= row_upper;
            match_lower <= row_lower;
        end
    end

    // straight from the registered flags, no extra cycle
    assign any_match = |match;

endmodule

`default_nettype wire

//--- hw/pad_window.sv
`timescale 1ns/1ps
`default_nettype none

// clamped pad window around each chamber A cluster
module pad_window #(
    parameter int n_clusters = copad_pkg::default_n_clusters
) (
    cluster_if.consumer                     gem_a,
    input  logic                            match_neighbor_pad,
    input  copad_pkg::delta_t               match_delta_pad,
    output copad_pkg::pad_t [n_clusters-1:0] win_min,
    output copad_pkg::pad_t [n_clusters-1:0] win_max
);

    // one spare bit so start + count + delta cannot wrap
    localparam int sum_width = copad_pkg::pad_width + 1;

    // widening only with neighbor pad matching on
    copad_pkg::pad_t delta_eff;

    assign delta_eff = match_neighbor_pad ? copad_pkg::pad_t'(match_delta_pad) : '0;

    // --------------------------------------------------
    // per cluster window
    // --------------------------------------------------
    genvar i;
    generate
        for (i = 0; i < n_clusters; i++) begin : g_win
            logic [sum_width-1:0] span_hi;
            logic                 at_left_edge;
            logic                 at_right_edge;

            // far end of the widened span
            assign span_hi = sum_width'(gem_a.pad[i])
                           + sum_width'(gem_a.cnt[i])
                           + sum_width'(delta_eff);

            // window would start below pad 0
            assign at_left_edge = gem_a.pad[i] < delta_eff;

            // window would run past the last pad
            assign at_right_edge = span_hi > sum_width'(copad_pkg::last_pad);

            assign win_min[i] = at_left_edge ? '0 : gem_a.pad[i] - delta_eff;

            // clamp to the roll end, else low bits of the sum
            assign win_max[i] = at_right_edge ? copad_pkg::last_pad
                                              : span_hi[copad_pkg::pad_width-1:0];
        end
    endgenerate

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the co-pad finder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module copad_finder_tb \
    -f filelist.f \
    -o copad_finder_sim

# the log decides the result, not the exit status
./obj_dir/copad_finder_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "result: pass"
else
    echo "result: fail"
    exit 1
fi

//--- verification/copad_finder_props.sv
`timescale 1ns/1ps
`default_nettype none

// output relations of the finder top level
module copad_finder_props #(
    parameter int n_clusters = copad_pkg::default_n_clusters
) (
    input logic                                  clock,
    input logic                                  arst_n,
    input logic                                  match_neighbor_roll,
    input logic [n_clusters-1:0]                 match,
    input logic [n_clusters-1:0]                 match_upper,
    input logic [n_clusters-1:0]                 match_lower,
    input logic [n_clusters-1:0][n_clusters-1:0] copad_a_b,
    input logic                                  any_match
);

    // summary flag agrees with the coincidence matrix
    a_any_match: assert property (@(posedge clock) disable iff (!arst_n)
        any_match == (|copad_a_b))
        else $error("any_match differs from the OR of copad_a_b");

    // neighbor flags are a subset of match
    a_upper_in_match: assert property (@(posedge clock) disable iff (!arst_n)
        (match_upper & ~match) == '0)
        else $error("match_upper bit set without its match bit");

    a_lower_in_match: assert property (@(posedge clock) disable iff (!arst_n)
        (match_lower & ~match) == '0)
        else $error("match_lower bit set without its match bit");

    // neighbor flags clear one cycle after neighbor roll matching is off
    a_no_neighbor: assert property (@(posedge clock) disable iff (!arst_n)
        !match_neighbor_roll |=> (match_upper == '0 && match_lower == '0))
        else $error("neighbor roll flag set with neighbor roll matching off");

    // registers held clear in reset
    a_reset_clear: assert property (@(posedge clock)
        !arst_n |-> (match == '0 && match_upper == '0 && match_lower == '0
                     && copad_a_b == '0 && !any_match))
        else $error("outputs not zero while reset is asserted");

endmodule

bind copad_finder copad_finder_props #(
    .n_clusters (n_clusters)
) u_props (
    .clock               (clock),
    .arst_n              (arst_n),
    .match_neighbor_roll (match_neighbor_roll),
    .match               (match),
    .match_upper         (match_upper),
    .match_lower         (match_lower),
    .copad_a_b           (copad_a_b),
    .any_match           (any_match)
);

`default_nettype wire

//--- verification/copad_finder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module copad_finder_tb;

    localparam int n = copad_pkg::default_n_clusters;

    // --------------------------------------------------
    // run length and watchdog
    // --------------------------------------------------
    localparam int n_directed  = 16;
    localparam int n_random    = 300;
    localparam int watchdog_ns = (n_directed + n_random + 20) * 100;

    logic clock;
    logic arst_n;

    // DUT inputs
    logic                                  match_neighbor_roll;
    logic                                  match_neighbor_pad;
    copad_pkg::delta_t                     match_delta_pad;
    logic [n-1:0]                          gem_a_vpf;
    copad_pkg::roll_t [n-1:0]              gem_a_roll;
    copad_pkg::pad_t  [n-1:0]              gem_a_pad;
    copad_pkg::cnt_t  [n-1:0]              gem_a_cnt;
    logic [n-1:0]                          gem_b_vpf;
    copad_pkg::roll_t [n-1:0]              gem_b_roll;
    copad_pkg::pad_t  [n-1:0]              gem_b_pad;
    copad_pkg::cnt_t  [n-1:0]              gem_b_cnt;

    // DUT outputs
    logic [n-1:0]                          match;
    logic [n-1:0]                          match_upper;
    logic [n-1:0]                          match_lower;
    logic [n-1:0][n-1:0]                   copad_a_b;
    logic                                  any_match;

    // next crossing, built by the tests before each step
    logic                                  nx_nb_roll;
    logic                                  nx_nb_pad;
    copad_pkg::delta_t                     nx_delta;
    logic [n-1:0]                          nx_a_vpf;
    copad_pkg::roll_t [n-1:0]              nx_a_roll;
    copad_pkg::pad_t  [n-1:0]              nx_a_pad;
    copad_pkg::cnt_t  [n-1:0]              nx_a_cnt;
    logic [n-1:0]                          nx_b_vpf;
    copad_pkg::roll_t [n-1:0]              nx_b_roll;
    copad_pkg::pad_t  [n-1:0]              nx_b_pad;
    copad_pkg::cnt_t  [n-1:0]              nx_b_cnt;

    // model results for the crossing now in the output registers
    logic [n-1:0][n-1:0]                   exp_copad;
    logic [n-1:0]                          exp_match;
    logic [n-1:0]                          exp_upper;
    logic [n-1:0]                          exp_lower;
    logic                                  exp_any;

    logic                                  have_prev;
    string                                 cur_test;
    string                                 prev_test;
    logic [31:0]                           lfsr;
    int                                    n_checks;
    int                                    n_errors;

    copad_finder #(
        .n_clusters (n)
    ) dut (
        .clock               (clock),
        .arst_n              (arst_n),
        .match_neighbor_roll (match_neighbor_roll),
        .match_neighbor_pad  (match_neighbor_pad),
        .match_delta_pad     (match_delta_pad),
        .gem_a_vpf           (gem_a_vpf),
        .gem_a_roll          (gem_a_roll),
        .gem_a_pad           (gem_a_pad),
        .gem_a_cnt           (gem_a_cnt),
        .gem_b_vpf           (gem_b_vpf),
        .gem_b_roll          (gem_b_roll),
        .gem_b_pad           (gem_b_pad),
        .gem_b_cnt           (gem_b_cnt),
        .match               (match),
        .match_upper         (match_upper),
        .match_lower         (match_lower),
        .copad_a_b           (copad_a_b),
        .any_match           (any_match)
    );

    // 100 ns clock
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // --------------------------------------------------
    // random source
    // --------------------------------------------------

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < count; k++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // --------------------------------------------------
    // checker
    // --------------------------------------------------
    task automatic compare(input logic [63:0] got, input logic [63:0] expected,
                           input string what);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("FAILED at time %0t: %s, got %h, expected %h",
                     $time, what, got, expected);
        end
    endtask

    task automatic check_outputs(input string tag);
        compare(64'(copad_a_b), 64'(exp_copad), {tag, ": copad_a_b"});
        compare(64'(match), 64'(exp_match), {tag, ": match"});
        compare(64'(match_upper), 64'(exp_upper), {tag, ": match_upper"});
        compare(64'(match_lower), 64'(exp_lower), {tag, ": match_lower"});
        compare(64'(any_match), 64'(exp_any), {tag, ": any_match"});
    endtask

    task automatic expect_zero(input string tag);
        exp_copad = '0;
        exp_match = '0;
        exp_upper = '0;
        exp_lower = '0;
        exp_any   = 1'b0;
        check_outputs(tag);
    endtask

    // --------------------------------------------------
    // reference model, window and roll rules
    // --------------------------------------------------
    task automatic predict;
        int  eff;
        int  lo;
        int  hi;
        int  b_end;
        int  ra;
        int  rb;
        bit  ov;
        bit  both;
        bit  same;
        bit  up;
        bit  low;
        exp_copad = '0;
        exp_match = '0;
        exp_upper = '0;
        exp_lower = '0;
        // widening only with neighbor pad mode on
        eff = nx_nb_pad ? int'(nx_delta) : 0;
        for (int i = 0; i < n; i++) begin
            lo = (int'(nx_a_pad[i]) < eff) ? 0 : int'(nx_a_pad[i]) - eff;
            hi = int'(nx_a_pad[i]) + int'(nx_a_cnt[i]) + eff;
            if (hi > 191) begin
                hi = 191;
            end
            ra = int'(nx_a_roll[i]);
            for (int j = 0; j < n; j++) begin
                b_end = int'(nx_b_pad[j]) + int'(nx_b_cnt[j]);
                rb    = int'(nx_b_roll[j]);
                ov    = (int'(nx_b_pad[j]) >= lo && int'(nx_b_pad[j]) <= hi)
                     || (b_end >= lo && b_end <= hi);
                both  = nx_a_vpf[i] && nx_b_vpf[j];
                same  = both && ra == rb && ov;
                up    = both && ov && nx_nb_roll && ra != 0 && ra == rb + 1;
                low   = both && ov && nx_nb_roll && ra != 7 && ra + 1 == rb;
                exp_copad[i][j] = same || up || low;
                exp_match[i] = exp_match[i] | same | up | low;
                exp_upper[i] = exp_upper[i] | up;
                exp_lower[i] = exp_lower[i] | low;
            end
        end
        exp_any = |exp_match;
    endtask

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    task automatic clear_next;
        nx_nb_roll = 1'b0;
        nx_nb_pad  = 1'b0;
        nx_delta   = '0;
        nx_a_vpf   = '0;
        nx_a_roll  = '0;
        nx_a_pad   = '0;
        nx_a_cnt   = '0;
        nx_b_vpf   = '0;
        nx_b_roll  = '0;
        nx_b_pad   = '0;
        nx_b_cnt   = '0;
    endtask

    task automatic set_a(input int idx, input int roll, input int pad, input int cnt);
        nx_a_vpf[idx]  = 1'b1;
        nx_a_roll[idx] = copad_pkg::roll_t'(roll);
        nx_a_pad[idx]  = copad_pkg::pad_t'(pad);
        nx_a_cnt[idx]  = copad_pkg::cnt_t'(cnt);
    endtask

    task automatic set_b(input int idx, input int roll, input int pad, input int cnt);
        nx_b_vpf[idx]  = 1'b1;
        nx_b_roll[idx] = copad_pkg::roll_t'(roll);
        nx_b_pad[idx]  = copad_pkg::pad_t'(pad);
        nx_b_cnt[idx]  = copad_pkg::cnt_t'(cnt);
    endtask

    // one crossing per clock, previous crossing checked at the falling edge
    task automatic step;
        @(posedge clock);
        match_neighbor_roll <= nx_nb_roll;
        match_neighbor_pad  <= nx_nb_pad;
        match_delta_pad     <= nx_delta;
        gem_a_vpf           <= nx_a_vpf;
        gem_a_roll          <= nx_a_roll;
        gem_a_pad           <= nx_a_pad;
        gem_a_cnt           <= nx_a_cnt;
        gem_b_vpf           <= nx_b_vpf;
        gem_b_roll          <= nx_b_roll;
        gem_b_pad           <= nx_b_pad;
        gem_b_cnt           <= nx_b_cnt;
        @(negedge clock);
        if (have_prev) begin
            check_outputs(prev_test);
        end
        predict();
        prev_test = cur_test;
        have_prev = 1'b1;
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset;
        cur_test = "reset";
        @(negedge clock);
        expect_zero("during reset");
        @(posedge clock);
        @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);
        expect_zero("after reset");
    endtask

    task automatic test_same_roll;
        cur_test = "same roll";
        clear_next();
        set_a(0, 2, 10, 2);
        set_b(0, 2, 12, 0);
        set_b(1, 2, 8, 2);
        // one pad past the span, no delta
        set_b(2, 2, 13, 0);
        set_b(3, 3, 10, 0);
        set_a(1, 5, 100, 0);
        set_b(4, 5, 100, 7);
        set_b(5, 5, 99, 0);
        step();
    endtask

    task automatic test_pad_window;
        cur_test = "pad window";
        clear_next();
        nx_nb_pad = 1'b1;
        nx_delta  = 4'd3;
        // clamped at pad 0
        set_a(0, 1, 1, 1);
        set_b(0, 1, 5, 0);
        set_b(1, 1, 6, 0);
        // clamped at pad 191
        set_a(1, 1, 188, 2);
        set_b(2, 1, 185, 0);
        set_b(3, 1, 184, 0);
        set_b(4, 1, 191, 0);
        // edges of an unclamped window
        set_a(2, 4, 50, 0);
        set_b(5, 4, 44, 3);
        set_b(6, 4, 43, 3);
        set_b(7, 4, 54, 0);
        step();
        // delta ignored without neighbor pad mode
        nx_nb_pad = 1'b0;
        step();
        nx_nb_pad = 1'b1;
        nx_delta  = 4'd15;
        set_a(3, 6, 10, 7);
        set_b(7, 6, 0, 0);
        step();
    endtask

    task automatic test_neighbor_roll;
        cur_test = "neighbor roll";
        clear_next();
        set_a(0, 0, 20, 0);
        set_b(0, 1, 20, 0);
        // roll 7 below roll 0 must not wrap
        set_b(4, 7, 20, 0);
        set_a(1, 7, 40, 0);
        set_b(1, 6, 40, 0);
        set_b(5, 0, 40, 0);
        set_a(2, 3, 60, 1);
        set_b(2, 2, 61, 0);
        set_b(3, 4, 59, 1);
        step();
        nx_nb_roll = 1'b1;
        step();
    endtask

    task automatic test_invalid;
        cur_test = "invalid clusters";
        clear_next();
        nx_nb_roll = 1'b1;
        set_a(0, 2, 30, 1);
        set_b(0, 2, 30, 1);
        nx_b_vpf[0] = 1'b0;
        set_a(1, 3, 70, 0);
        set_b(1, 3, 70, 0);
        nx_a_vpf[1] = 1'b0;
        step();
    endtask

    // clusters bunched near both roll ends so matches are common
    task automatic random_cluster(output logic vpf, output copad_pkg::roll_t roll,
                                  output copad_pkg::pad_t pad, output copad_pkg::cnt_t cnt);
        logic [31:0] r;
        take_bits(2, r);
        vpf = r[1:0] != 2'b00;
        take_bits(3, r);
        roll = copad_pkg::roll_t'(r);
        take_bits(6, r);
        pad = copad_pkg::pad_t'(r[4:0]) + (r[5] ? 8'd160 : 8'd0);
        take_bits(3, r);
        cnt = copad_pkg::cnt_t'(r);
    endtask

    task automatic test_random;
        logic [31:0]       r;
        logic              v;
        copad_pkg::roll_t  rl;
        copad_pkg::pad_t   pd;
        copad_pkg::cnt_t   ct;
        cur_test = "random";
        for (int t = 0; t < n_random; t++) begin
            take_bits(6, r);
            nx_nb_roll = r[0];
            nx_nb_pad  = r[1];
            nx_delta   = copad_pkg::delta_t'(r[5:2]);
            for (int i = 0; i < n; i++) begin
                random_cluster(v, rl, pd, ct);
                nx_a_vpf[i]  = v;
                nx_a_roll[i] = rl;
                nx_a_pad[i]  = pd;
                nx_a_cnt[i]  = ct;
                random_cluster(v, rl, pd, ct);
                nx_b_vpf[i]  = v;
                nx_b_roll[i] = rl;
                nx_b_pad[i]  = pd;
                nx_b_cnt[i]  = ct;
            end
            step();
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        n_checks            = 0;
        n_errors            = 0;
        have_prev           = 1'b0;
        lfsr                = 32'hb29c_01e3;
        arst_n              = 1'b0;
        match_neighbor_roll = 1'b0;
        match_neighbor_pad  = 1'b0;
        match_delta_pad     = '0;
        gem_a_vpf           = '0;
        gem_a_roll          = '0;
        gem_a_pad           = '0;
        gem_a_cnt           = '0;
        gem_b_vpf           = '0;
        gem_b_roll          = '0;
        gem_b_pad           = '0;
        gem_b_cnt           = '0;
        clear_next();

        test_reset();
        test_same_roll();
        test_pad_window();
        test_neighbor_roll();
        test_invalid();
        test_random();
        // last crossing still in the registers
        cur_test = "flush";
        clear_next();
        step();

        $display("summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
